// File: cop_settings.svh
// Coprocessor subsystem settings for queue sizing and instruction encodings
`ifndef COP_SETTINGS_SVH
`define COP_SETTINGS_SVH

// ======================================================================
// Command queue
// ======================================================================

// Number of ESC commands buffered between CPU and FPU
`define COP_QUEUE_DEPTH 4

// ======================================================================
// Instruction encodings
// ======================================================================

// FWAIT opcode, stalls the CPU until the FPU is idle
`define OPC_FWAIT 8'h9B

// Top five opcode bits shared by ESC D8..DF
`define ESC_PREFIX 5'b11011

`endif

// File: cop_pkg.sv
// Coprocessor package with bus width types and state machine encodings
`default_nettype none

package cop_pkg;

    // ==================================================================
    // Width types
    // ==================================================================

    // Instruction opcode byte
    typedef logic [7:0] opcode_t;
    // ModR/M byte, mod field in bits 7:6
    typedef logic [7:0] modrm_t;
    // 20-bit physical address
    typedef logic [19:0] addr_t;
    // Memory data word, also the accumulator
    typedef logic [15:0] word_t;

    // ==================================================================
    // State machines
    // ==================================================================

    // CPU-side dispatcher
    typedef enum logic [2:0] {
        DISP_IDLE,
        DISP_DECODE,
        DISP_DISPATCH,
        DISP_WAIT_FPU,
        DISP_COMPLETE
    } dispatch_state_t;

    // FPU execution unit
    typedef enum logic [1:0] {
        EXEC_IDLE,
        EXEC_DECODE,
        EXEC_MEM_ACCESS,
        EXEC_RETIRE
    } exec_state_t;

    // Operation field from opcode bits 2:0, 5..7 fold into OP_BAD
    typedef enum logic [2:0] {
        OP_LOAD  = 3'd0,
        OP_ADD   = 3'd1,
        OP_SUB   = 3'd2,
        OP_STORE = 3'd3,
        OP_CLEAR = 3'd4,
        OP_BAD   = 3'd5
    } fpu_op_t;

endpackage

`default_nettype wire

// File: esc_dispatcher.sv
// ESC dispatcher that decodes CPU instructions, queues ESC commands and handles FWAIT
`timescale 1ns/1ps
`default_nettype none

`include "cop_settings.svh"

module esc_dispatcher (
    input  wire logic             clk,
    input  wire logic             reset,

    // Instruction port
    input  wire cop_pkg::opcode_t instruction_opcode,
    input  wire cop_pkg::modrm_t  instruction_modrm,
    input  wire cop_pkg::addr_t   instruction_addr,
    input  wire logic             instruction_valid,
    output logic                  instruction_ack,

    // Command queue push side
    output logic                  push,
    output cop_pkg::opcode_t      push_opcode,
    output cop_pkg::modrm_t       push_modrm,
    output cop_pkg::addr_t        push_addr,
    input  wire logic             full,

    // Queue empty and FPU not busy
    input  wire logic             queue_idle
);

    import cop_pkg::*;

    // ==================================================================
    // Instruction buffer and decode
    // ==================================================================

    dispatch_state_t state;
    dispatch_state_t next_state;

    opcode_t cur_opcode;
    modrm_t  cur_modrm;
    addr_t   cur_addr;

    logic is_esc;
    logic is_fwait;

    // ESC range D8..DF
    assign is_esc   = (cur_opcode[7:3] == `ESC_PREFIX);
    assign is_fwait = (cur_opcode == `OPC_FWAIT);

    // Capture on acceptance in IDLE
    always_ff @(posedge clk) begin
        if (state == DISP_IDLE && instruction_valid) begin
            cur_opcode <= instruction_opcode;
            cur_modrm  <= instruction_modrm;
            cur_addr   <= instruction_addr;
        end
    end

    // ==================================================================
    // Control state machine
    // ==================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DISP_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            DISP_IDLE: begin
                if (instruction_valid) begin
                    next_state = DISP_DECODE;
                end
            end
            DISP_DECODE: begin
                // ESC to queue, FWAIT to poll, all else completes
                if (is_esc) begin
                    next_state = DISP_DISPATCH;
                end else if (is_fwait) begin
                    next_state = DISP_WAIT_FPU;
                end else begin
                    next_state = DISP_COMPLETE;
                end
            end
            DISP_DISPATCH: begin
                // Hold here while the queue is full
                if (!full) begin
                    next_state = DISP_COMPLETE;
                end
            end
            DISP_WAIT_FPU: begin
                if (queue_idle) begin
                    next_state = DISP_COMPLETE;
                end
            end
            DISP_COMPLETE: begin
                next_state = DISP_IDLE;
            end
            default: begin
                next_state = DISP_IDLE;
            end
        endcase
    end

    // ==================================================================
    // Outputs
    // ==================================================================

    // One push per ESC, only with room in the queue
    assign push        = (state == DISP_DISPATCH) && !full;
    assign push_opcode = cur_opcode;
    assign push_modrm  = cur_modrm;
    assign push_addr   = cur_addr;

    // Single-cycle ack
    assign instruction_ack = (state == DISP_COMPLETE);

endmodule

`default_nettype wire

// File: cop_cmd_queue.sv
// Coprocessor command FIFO between the CPU dispatcher and the FPU execution unit
`timescale 1ns/1ps
`default_nettype none

`include "cop_settings.svh"

module cop_cmd_queue #(
    parameter int DEPTH = `COP_QUEUE_DEPTH
) (
    input  wire logic             clk,
    input  wire logic             reset,

    // Push side from dispatcher
    input  wire logic             push,
    input  wire cop_pkg::opcode_t push_opcode,
    input  wire cop_pkg::modrm_t  push_modrm,
    input  wire cop_pkg::addr_t   push_addr,
    output logic                  full,

    // Head of queue to execution unit
    output cop_pkg::opcode_t      head_opcode,
    output cop_pkg::modrm_t       head_modrm,
    output cop_pkg::addr_t        head_addr,
    output logic                  empty,
    input  wire logic             pop,

    // Combined idle status
    input  wire logic             fpu_busy,
    output logic                  queue_idle
);

    import cop_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Command storage
    opcode_t opcode_mem [DEPTH];
    modrm_t  modrm_mem  [DEPTH];
    addr_t   addr_mem   [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    // Wrap at DEPTH, works for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // ==================================================================
    // Pointers and occupancy
    // ==================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Push and pop together leave count unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Write slot, visible at head one cycle later
    always_ff @(posedge clk) begin
        if (do_push) begin
            opcode_mem[wr_ptr] <= push_opcode;
            modrm_mem[wr_ptr]  <= push_modrm;
            addr_mem[wr_ptr]   <= push_addr;
        end
    end

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    assign head_opcode = opcode_mem[rd_ptr];
    assign head_modrm  = modrm_mem[rd_ptr];
    assign head_addr   = addr_mem[rd_ptr];

    // Nothing queued and nothing executing
    assign queue_idle = empty && !fpu_busy;

endmodule

`default_nettype wire

// File: fpu_exec_unit.sv
// FPU execution unit that pops commands, runs bus cycles and keeps the accumulator
`timescale 1ns/1ps
`default_nettype none

module fpu_exec_unit (
    input  wire logic             clk,
    input  wire logic             reset,

    // Queue head
    input  wire cop_pkg::opcode_t head_opcode,
    input  wire cop_pkg::modrm_t  head_modrm,
    input  wire cop_pkg::addr_t   head_addr,
    input  wire logic             empty,
    output logic                  pop,

    // Status
    output logic                  fpu_busy,
    output logic                  fpu_error,

    // Memory bus
    output cop_pkg::addr_t        mem_addr,
    output cop_pkg::word_t        mem_wdata,
    input  wire cop_pkg::word_t   mem_rdata,
    output logic                  mem_access,
    output logic                  mem_wr_en,
    input  wire logic             mem_ack
);

    import cop_pkg::*;

    exec_state_t state;
    exec_state_t next_state;

    // Current command fields
    logic [2:0] cmd_op_bits;
    logic [1:0] cmd_mod;
    addr_t      cmd_addr;

    word_t   rdata_q;
    word_t   acc;
    fpu_op_t cmd_op;
    logic    is_mem_op;
    logic    reg_form;
    logic    mem_valid;

    // ==================================================================
    // Command decode
    // ==================================================================

    always_comb begin
        case (cmd_op_bits)
            3'd0:    cmd_op = OP_LOAD;
            3'd1:    cmd_op = OP_ADD;
            3'd2:    cmd_op = OP_SUB;
            3'd3:    cmd_op = OP_STORE;
            3'd4:    cmd_op = OP_CLEAR;
            default: cmd_op = OP_BAD;
        endcase
    end

    assign is_mem_op = (cmd_op inside {OP_LOAD, OP_ADD, OP_SUB, OP_STORE});
    // mod == 3 is register form, no bus cycle
    assign reg_form  = (cmd_mod == 2'b11);
    assign mem_valid = is_mem_op && !reg_form;

    // Take the head while idle
    assign pop = (state == EXEC_IDLE) && !empty;

    always_ff @(posedge clk) begin
        if (pop) begin
            cmd_op_bits <= head_opcode[2:0];
            cmd_mod     <= head_modrm[7:6];
            cmd_addr    <= head_addr;
        end
    end

    // ==================================================================
    // Execution state machine
    // ==================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= EXEC_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            EXEC_IDLE:       if (!empty) next_state = EXEC_DECODE;
            EXEC_DECODE:     next_state = mem_valid ? EXEC_MEM_ACCESS : EXEC_RETIRE;
            // Stall until the bus answers
            EXEC_MEM_ACCESS: if (mem_ack) next_state = EXEC_RETIRE;
            default:         next_state = EXEC_IDLE;
        endcase
    end

    // Read data held for retire
    always_ff @(posedge clk) begin
        if (state == EXEC_MEM_ACCESS && mem_ack) begin
            rdata_q <= mem_rdata;
        end
    end

    // ==================================================================
    // Retire, accumulator and sticky error
    // ==================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            acc       <= '0;
            fpu_error <= 1'b0;
        end else if (state == EXEC_RETIRE) begin
            case (cmd_op)
                OP_LOAD:  if (!reg_form) acc <= rdata_q;
                OP_ADD:   if (!reg_form) acc <= acc + rdata_q;
                OP_SUB:   if (!reg_form) acc <= acc - rdata_q;
                OP_CLEAR: begin
                    acc       <= '0;
                    fpu_error <= 1'b0;
                end
                OP_BAD:   fpu_error <= 1'b1;
                default:  acc <= acc;
            endcase
            // Register-form memory op is an error
            if (is_mem_op && reg_form) begin
                fpu_error <= 1'b1;
            end
        end
    end

    // Bus signals held for the whole access
    assign mem_access = (state == EXEC_MEM_ACCESS);
    assign mem_wr_en  = mem_access && (cmd_op == OP_STORE);
    assign mem_addr   = cmd_addr;
    assign mem_wdata  = acc;

    assign fpu_busy = (state != EXEC_IDLE);

endmodule

`default_nettype wire

// File: cpu_fpu_system.sv
// CPU and FPU coprocessor subsystem top with dispatcher, command queue and FPU
`timescale 1ns/1ps
`default_nettype none

`include "cop_settings.svh"

module cpu_fpu_system (
    input  wire logic             clk,
    input  wire logic             reset,

    // Instruction port
    input  wire cop_pkg::opcode_t instruction_opcode,
    input  wire cop_pkg::modrm_t  instruction_modrm,
    input  wire cop_pkg::addr_t   instruction_addr,
    input  wire logic             instruction_valid,
    output logic                  instruction_ack,

    // Memory port, FPU is the only master
    output cop_pkg::addr_t        mem_addr,
    output cop_pkg::word_t        mem_wdata,
    input  wire cop_pkg::word_t   mem_rdata,
    output logic                  mem_access,
    output logic                  mem_wr_en,
    input  wire logic             mem_ack,

    // Status
    output logic                  system_busy,
    output logic                  fpu_interrupt
);

    import cop_pkg::*;

    // ==================================================================
    // Internal connections
    // ==================================================================

    // Dispatcher to queue
    logic    push;
    opcode_t push_opcode;
    modrm_t  push_modrm;
    addr_t   push_addr;
    logic    full;

    // Queue to FPU
    opcode_t head_opcode;
    modrm_t  head_modrm;
    addr_t   head_addr;
    logic    empty;
    logic    pop;

    // Status
    logic fpu_busy;
    logic fpu_error;
    logic queue_idle;

    esc_dispatcher dispatcher_i (
        .clk                (clk),
        .reset              (reset),
        .instruction_opcode (instruction_opcode),
        .instruction_modrm  (instruction_modrm),
        .instruction_addr   (instruction_addr),
        .instruction_valid  (instruction_valid),
        .instruction_ack    (instruction_ack),
        .push               (push),
        .push_opcode        (push_opcode),
        .push_modrm         (push_modrm),
        .push_addr          (push_addr),
        .full               (full),
        .queue_idle         (queue_idle)
    );

    cop_cmd_queue #(
        .DEPTH (`COP_QUEUE_DEPTH)
    ) queue_i (
        .clk         (clk),
        .reset       (reset),
        .push        (push),
        .push_opcode (push_opcode),
        .push_modrm  (push_modrm),
        .push_addr   (push_addr),
        .full        (full),
        .head_opcode (head_opcode),
        .head_modrm  (head_modrm),
        .head_addr   (head_addr),
        .empty       (empty),
        .pop         (pop),
        .fpu_busy    (fpu_busy),
        .queue_idle  (queue_idle)
    );

    fpu_exec_unit fpu_i (
        .clk         (clk),
        .reset       (reset),
        .head_opcode (head_opcode),
        .head_modrm  (head_modrm),
        .head_addr   (head_addr),
        .empty       (empty),
        .pop         (pop),
        .fpu_busy    (fpu_busy),
        .fpu_error   (fpu_error),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_access  (mem_access),
        .mem_wr_en   (mem_wr_en),
        .mem_ack     (mem_ack)
    );

    // Busy while anything is queued or executing
    assign system_busy   = !queue_idle;
    assign fpu_interrupt = fpu_error;

endmodule

`default_nettype wire

// File: tb_cpu_fpu_system.sv
// Self-checking testbench for the CPU and FPU coprocessor subsystem
`timescale 1ns/1ps
`default_nettype none

`include "cop_settings.svh"

module tb_cpu_fpu_system;

    import cop_pkg::*;

    localparam int NUM_INSTR       = 400;
    localparam int ACK_LIMIT       = 1000;
    localparam int WATCHDOG_CYCLES = NUM_INSTR * (`COP_QUEUE_DEPTH + 2) * 12;
    // Small window so loads hit earlier stores
    localparam logic [19:0] ADDR_BASE = 20'hA3F00;

    logic    clk;
    logic    reset;
    opcode_t instruction_opcode;
    modrm_t  instruction_modrm;
    addr_t   instruction_addr;
    logic    instruction_valid;
    logic    instruction_ack;
    addr_t   mem_addr;
    word_t   mem_wdata;
    word_t   mem_rdata;
    logic    mem_access;
    logic    mem_wr_en;
    logic    mem_ack;
    logic    system_busy;
    logic    fpu_interrupt;

    integer seed;

    // Sparse memory seen by the DUT
    word_t bus_mem [addr_t];
    // Reference model state
    word_t model_mem [addr_t];
    word_t model_acc;
    logic  model_err;

    // Expected bus accesses in program order
    logic  exp_wr    [$];
    addr_t exp_addr  [$];
    word_t exp_data  [$];
    int    exp_delay [$];

    int   access_total;
    int   access_seen;
    int   ack_count;
    int   stall_count;
    int   wait_left;
    logic waiting;
    logic slow_phase;

    cpu_fpu_system dut_i (
        .clk                (clk),
        .reset              (reset),
        .instruction_opcode (instruction_opcode),
        .instruction_modrm  (instruction_modrm),
        .instruction_addr   (instruction_addr),
        .instruction_valid  (instruction_valid),
        .instruction_ack    (instruction_ack),
        .mem_addr           (mem_addr),
        .mem_wdata          (mem_wdata),
        .mem_rdata          (mem_rdata),
        .mem_access         (mem_access),
        .mem_wr_en          (mem_wr_en),
        .mem_ack            (mem_ack),
        .system_busy        (system_busy),
        .fpu_interrupt      (fpu_interrupt)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // ==================================================================
    // Reporting and helpers
    // ==================================================================

    task automatic fail_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        $display("Test FAILED");
        $fatal(1, "Wrong value in check %s", name);
    endtask

    task automatic fail_plain(input string what);
        $display("Test FAILED");
        $fatal(1, "%s", what);
    endtask

    // Fill value for unwritten words from every address bit
    function automatic word_t fill_word(input addr_t a);
        return (a[15:0] ^ {a[3:0], a[19:8]}) + 16'h3c5a;
    endfunction

    function automatic word_t model_read(input addr_t a);
        if (model_mem.exists(a)) begin
            return model_mem[a];
        end
        return fill_word(a);
    endfunction

    // Short delays normally and long ones to back up the queue
    function automatic int pick_delay();
        logic [31:0] r;
        r = $random(seed);
        if (slow_phase) begin
            return 10 + int'(r % 32'd20);
        end
        return int'(r % 32'd5);
    endfunction

    // ==================================================================
    // Reference model for one ESC command in program order
    // ==================================================================

    task automatic apply_model(input opcode_t opc, input modrm_t modrm, input addr_t addr);
        logic [2:0] op;
        logic       reg_form;
        op       = opc[2:0];
        reg_form = (modrm[7:6] == 2'b11);
        if (op <= 3'd3 && reg_form) begin
            // Register form of a memory op makes no bus cycle
            model_err = 1'b1;
        end else if (op <= 3'd3) begin
            exp_wr.push_back(op == 3'd3);
            exp_addr.push_back(addr);
            exp_data.push_back(model_acc);
            exp_delay.push_back(pick_delay());
            access_total++;
            case (op)
                3'd0:    model_acc = model_read(addr);
                3'd1:    model_acc = model_acc + model_read(addr);
                3'd2:    model_acc = model_acc - model_read(addr);
                default: model_mem[addr] = model_acc;
            endcase
        end else if (op == 3'd4) begin
            model_acc = '0;
            model_err = 1'b0;
        end else begin
            model_err = 1'b1;
        end
    endtask

    // ==================================================================
    // Memory responder
    // ==================================================================

    task automatic check_access();
        if (exp_wr.size() == 0) begin
            fail_plain("Memory access seen with no pending memory command");
        end else begin
            assert (mem_wr_en == exp_wr[0])
                else fail_value("access direction", 32'(exp_wr[0]), 32'(mem_wr_en));
            assert (mem_addr == exp_addr[0])
                else fail_value("access address", 32'(exp_addr[0]), 32'(mem_addr));
            if (mem_wr_en) begin
                assert (mem_wdata == exp_data[0])
                    else fail_value("store data", 32'(exp_data[0]), 32'(mem_wdata));
                bus_mem[mem_addr] = mem_wdata;
            end else begin
                mem_rdata = bus_mem.exists(mem_addr) ? bus_mem[mem_addr] : fill_word(mem_addr);
            end
            exp_wr.delete(0);
            exp_addr.delete(0);
            exp_data.delete(0);
            exp_delay.delete(0);
            access_seen++;
        end
    endtask

    // One-cycle ack after the wait drawn for this command
    always @(negedge clk) begin
        mem_ack = 1'b0;
        if (!reset && mem_access) begin
            if (!waiting) begin
                wait_left = (exp_delay.size() > 0) ? exp_delay[0] : 0;
                waiting   = 1'b1;
            end
            if (wait_left == 0) begin
                check_access();
                mem_ack = 1'b1;
                waiting = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    // Acks counted on the rising edge and read on the falling one
    always @(posedge clk) begin
        if (!reset && instruction_ack) begin
            ack_count++;
        end
    end

    // ==================================================================
    // Stimulus
    // ==================================================================

    task automatic gen_instruction(output opcode_t opc, output modrm_t modrm,
                                   output addr_t addr);
        logic [31:0] r;
        int          kind;
        r     = $random(seed);
        kind  = int'(r % 32'd100);
        r     = $random(seed);
        modrm = r[7:0];
        addr  = ADDR_BASE + {15'd0, r[11:8], 1'b0};
        if (kind < 60) begin
            opc = {`ESC_PREFIX, r[18:16]};
        end else if (kind < 75) begin
            opc = `OPC_FWAIT;
        end else begin
            // Step out of the ESC range and FWAIT
            opc = r[31:24];
            while (opc[7:3] == `ESC_PREFIX || opc == `OPC_FWAIT) begin
                opc = opc + 8'd1;
            end
        end
    endtask

    task automatic run_instruction(input int idx, input opcode_t opc, input modrm_t modrm,
                                   input addr_t addr);
        int   cycles;
        int   latency;
        logic is_esc;
        logic is_fwait;
        is_esc             = (opc[7:3] == `ESC_PREFIX);
        is_fwait           = (opc == `OPC_FWAIT);
        instruction_opcode = opc;
        instruction_modrm  = modrm;
        instruction_addr   = addr;
        instruction_valid  = 1'b1;
        if (is_esc) begin
            apply_model(opc, modrm, addr);
        end
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!instruction_ack && cycles < ACK_LIMIT);
        if (!instruction_ack) begin
            fail_plain($sformatf("Instruction %0d was never acknowledged", idx));
        end else begin
            assert (ack_count == idx) else fail_value("ack count", 32'(idx), 32'(ack_count));
            // Dispatcher sits one edge in COMPLETE after the previous ack
            latency = (idx == 0) ? cycles : cycles - 1;
            if (is_fwait) begin
                assert (!system_busy) else fail_value("fwait busy", 32'd0, 32'(system_busy));
                assert (access_seen == access_total)
                    else fail_value("fwait accesses", 32'(access_total), 32'(access_seen));
                assert (fpu_interrupt == model_err)
                    else fail_value("fwait error flag", 32'(model_err), 32'(fpu_interrupt));
            end else if (is_esc) begin
                assert (latency >= 3) else fail_value("esc ack latency", 32'd3, 32'(latency));
                if (latency > 3) begin
                    stall_count++;
                end
            end else begin
                assert (latency == 2) else fail_value("other ack latency", 32'd2, 32'(latency));
            end
        end
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial begin
        opcode_t opc;
        modrm_t  modrm;
        addr_t   addr;
        clk                = 1'b0;
        reset              = 1'b1;
        instruction_opcode = '0;
        instruction_modrm  = '0;
        instruction_addr   = '0;
        instruction_valid  = 1'b0;
        mem_rdata          = '0;
        mem_ack            = 1'b0;
        seed               = 32'h3139_c1ef;
        model_acc          = '0;
        model_err          = 1'b0;
        access_total       = 0;
        access_seen        = 0;
        ack_count          = 0;
        stall_count        = 0;
        wait_left          = 0;
        waiting            = 1'b0;
        slow_phase         = 1'b0;

        repeat (8) @(negedge clk);
        reset = 1'b0;

        // Quiet outputs after reset
        repeat (2) begin
            @(negedge clk);
            assert (!instruction_ack) else fail_value("reset ack", 32'd0, 32'(instruction_ack));
            assert (!mem_access) else fail_value("reset mem_access", 32'd0, 32'(mem_access));
            assert (!system_busy) else fail_value("reset busy", 32'd0, 32'(system_busy));
            assert (!fpu_interrupt)
                else fail_value("reset interrupt", 32'd0, 32'(fpu_interrupt));
        end

        for (int i = 0; i < NUM_INSTR; i++) begin
            // Two windows of slow memory
            slow_phase = (i >= 120 && i < 180) || (i >= 290 && i < 330);
            gen_instruction(opc, modrm, addr);
            run_instruction(i, opc, modrm, addr);
        end
        slow_phase = 1'b0;

        // Closing FWAIT drains the queue for the last checks
        run_instruction(NUM_INSTR, `OPC_FWAIT, 8'h00, 20'h00000);
        instruction_valid = 1'b0;
        repeat (2) @(negedge clk);

        assert (ack_count == NUM_INSTR + 1)
            else fail_value("total acks", 32'(NUM_INSTR + 1), 32'(ack_count));
        assert (stall_count > 0)
            else fail_plain("Slow memory never filled the command queue");

        $display("Test OK");
        $finish;
    end

    // Bound on the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_plain("Timeout, the run did not finish in the allowed cycles");
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
cop_pkg.sv
esc_dispatcher.sv
cop_cmd_queue.sv
fpu_exec_unit.sv
cpu_fpu_system.sv
tb_cpu_fpu_system.sv

// File: Makefile
# Verilator build and run for the CPU/FPU coprocessor subsystem

VERILATOR ?= verilator
TOP       ?= tb_cpu_fpu_system
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FLIST)) cop_settings.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
